/* rtl/decomp_cfg_pkg.sv */
package decomp_cfg_pkg;

	// one line of the memory path
	localparam int unsigned LINE_W = 64;

	// page geometry
	localparam int unsigned NUM_CHUNKS  = 4;
	localparam int unsigned CHUNK_LINES = 16;
	localparam int unsigned PAGE_LINES  = NUM_CHUNKS * CHUNK_LINES;
	localparam int unsigned CNT_W       = 7; // holds PAGE_LINES

	// line FIFOs on both sides of the engine
	localparam int unsigned FIFO_DEPTH = 8;
	localparam int unsigned PTR_W      = 3;

	// response code that rides along with every input line
	localparam int unsigned RESP_W = 2;

endpackage

/* rtl/decomp_ctrl_pkg.sv */
package decomp_ctrl_pkg;

	typedef enum logic [2:0] {
		IDLE,
		METADATA,
		EXPAND,
		FILL_ZEROS,
		COPY_LINES,
		DONE,
		BUS_ERROR
	} decomp_state_e;

	typedef enum logic [1:0] {
		REG_CTRL   = 2'd0,
		REG_STATUS = 2'd1,
		REG_LINES  = 2'd2
	} reg_addr_e;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'd0,
		RESP_SLVERR = 2'd2
	} resp_e;

	// CTRL write bits
	localparam int unsigned CTRL_START_BIT = 0;
	localparam int unsigned CTRL_CLEAR_BIT = 1;

	// STATUS read bits
	localparam int unsigned STAT_BUSY_BIT = 0;
	localparam int unsigned STAT_DONE_BIT = 1;
	localparam int unsigned STAT_ERR_BIT  = 2;

endpackage

/* rtl/line_fifo.sv */
`timescale 1ns/1ps

module line_fifo #(
	parameter int unsigned WIDTH = 66,
	parameter int unsigned DEPTH = 8,
	parameter int unsigned PTR_W = 3
) (
	input  logic             clk_i,
	input  logic             rst_ni,
	input  logic             push_valid,
	input  logic [WIDTH-1:0] push_data,
	output logic             push_ready,
	output logic             pop_valid,
	input  logic             pop_ready,
	output logic [WIDTH-1:0] pop_data
);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             init_done; // ready stays low right after reset
	logic             full;
	logic             do_push;
	logic             do_pop;

	assign full       = (count == (PTR_W+1)'(DEPTH));
	assign push_ready = init_done && (!full || pop_ready); // pop frees a slot when full
	assign pop_valid  = (count != '0);
	assign pop_data   = mem[rd_ptr];
	assign do_push    = push_valid && push_ready;
	assign do_pop     = pop_valid && pop_ready;

	always_ff @(posedge clk_i) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			init_done <= 1'b0;
		end else begin
			init_done <= 1'b1;
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ; // both or neither leaves count alone
			endcase
		end
	end

endmodule

/* rtl/decomp_regs.sv */
`timescale 1ns/1ps

module decomp_regs
	import decomp_cfg_pkg::*;
	import decomp_ctrl_pkg::*;
(
	input  logic        clk_i,
	input  logic        rst_ni,
	input  logic        reg_valid,
	input  logic        reg_write,
	input  reg_addr_e   reg_addr,
	input  logic [31:0] reg_wdata,
	output logic        reg_ready,
	output logic        reg_rvalid,
	output logic [31:0] reg_rdata,
	input  logic        busy,
	input  logic        done_pulse,
	input  logic        bus_error,
	input  logic        line_pulse,
	output logic        start,
	output logic        err_clear
);

	logic             accept;
	logic             acc_q;
	logic             ctrl_wr;
	logic             done_q;
	logic [CNT_W-1:0] line_cnt;
	logic [31:0]      rd_val;

	assign reg_ready = !acc_q; // one dead cycle after every access
	assign accept    = reg_valid && reg_ready;
	assign ctrl_wr   = accept && reg_write && (reg_addr == REG_CTRL);

	always_comb begin
		rd_val = '0;
		case (reg_addr)
			REG_STATUS: begin
				rd_val[STAT_BUSY_BIT] = busy;
				rd_val[STAT_DONE_BIT] = done_q;
				rd_val[STAT_ERR_BIT]  = bus_error;
			end
			REG_LINES: rd_val[CNT_W-1:0] = line_cnt;
			default: ; // CTRL is write only
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			acc_q      <= 1'b0;
			reg_rvalid <= 1'b0;
			start      <= 1'b0;
			err_clear  <= 1'b0;
			done_q     <= 1'b0;
			line_cnt   <= '0;
		end else begin
			acc_q      <= accept;
			reg_rvalid <= accept && !reg_write;
			// a start while the engine is busy or stuck in error is dropped here
			start      <= ctrl_wr && reg_wdata[CTRL_START_BIT] && !busy && !bus_error;
			err_clear  <= ctrl_wr && reg_wdata[CTRL_CLEAR_BIT];
			if (start)
				done_q <= 1'b0;
			else if (done_pulse)
				done_q <= 1'b1;
			if (start)
				line_cnt <= '0;
			else if (line_pulse)
				line_cnt <= line_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept && !reg_write)
			reg_rdata <= rd_val;
	end

endmodule

/* rtl/page_decompressor.sv */
`timescale 1ns/1ps

module page_decompressor
	import decomp_cfg_pkg::*;
	import decomp_ctrl_pkg::*;
(
	input  logic                     clk_i,
	input  logic                     rst_ni,
	input  logic                     start,
	input  logic                     err_clear,
	input  logic                     pop_valid,
	input  logic [LINE_W+RESP_W-1:0] pop_data,
	output logic                     pop_ready,
	output logic                     push_valid,
	output logic [LINE_W-1:0]        push_data,
	input  logic                     push_ready,
	output logic                     busy,
	output logic                     done_pulse,
	output logic                     bus_error,
	output logic                     line_pulse
);

	decomp_state_e         state;
	logic [NUM_CHUNKS-1:0] zero_mask;  // set bit = chunk is all zeros
	logic [NUM_CHUNKS-1:0] chunk_done;
	logic [NUM_CHUNKS-1:0] chunk_sel;  // one-hot, lowest unfinished chunk
	logic [CNT_W-1:0]      line_cnt;
	logic                  pop_ok;
	logic                  last_line;
	logic                  push_fire;
	logic                  pop_bad;

	assign chunk_sel = ~chunk_done & (chunk_done + 1'b1);
	assign pop_ok    = (pop_data[LINE_W +: RESP_W] == RESP_OKAY);
	assign last_line = (line_cnt == CNT_W'(CHUNK_LINES - 1));
	assign push_fire = push_valid && push_ready;
	assign pop_bad   = pop_valid && pop_ready && !pop_ok;

	assign busy       = (state != IDLE) && (state != BUS_ERROR);
	assign done_pulse = (state == DONE); // DONE lasts a single cycle
	assign bus_error  = (state == BUS_ERROR);
	assign line_pulse = push_fire;

	always_comb begin
		pop_ready  = 1'b0;
		push_valid = 1'b0;
		push_data  = '0;
		case (state)
			METADATA: pop_ready = 1'b1;
			FILL_ZEROS: push_valid = 1'b1;
			COPY_LINES: begin
				pop_ready  = push_ready; // only take a line when it can move on
				push_valid = pop_valid && pop_ok;
				push_data  = pop_data[LINE_W-1:0];
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state      <= IDLE;
			zero_mask  <= '0;
			chunk_done <= '0;
			line_cnt   <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (start)
						state <= METADATA;
				end
				METADATA: begin
					if (pop_valid) begin
						if (pop_ok) begin
							zero_mask  <= pop_data[NUM_CHUNKS-1:0];
							chunk_done <= '0;
							state      <= EXPAND;
						end else begin
							state <= BUS_ERROR;
						end
					end
				end
				EXPAND: begin
					line_cnt <= '0;
					if (&chunk_done)
						state <= DONE;
					else if (|(chunk_sel & zero_mask))
						state <= FILL_ZEROS;
					else
						state <= COPY_LINES;
				end
				FILL_ZEROS: begin
					if (push_fire) begin
						line_cnt <= line_cnt + 1'b1;
						if (last_line) begin
							chunk_done <= chunk_done | chunk_sel;
							state      <= EXPAND;
						end
					end
				end
				COPY_LINES: begin
					if (pop_bad) begin
						state <= BUS_ERROR; // bad line is consumed, not pushed
					end else if (push_fire) begin
						line_cnt <= line_cnt + 1'b1;
						if (last_line) begin
							chunk_done <= chunk_done | chunk_sel;
							state      <= EXPAND;
						end
					end
				end
				DONE: state <= IDLE;
				BUS_ERROR: begin
					// sticky until a clear command
					if (err_clear)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

/* rtl/decomp_top.sv */
`timescale 1ns/1ps

module decomp_top
	import decomp_cfg_pkg::*;
	import decomp_ctrl_pkg::*;
(
	input  logic              clk_i,
	input  logic              rst_ni,
	input  logic              in_valid,
	input  logic [LINE_W-1:0] in_data,
	input  logic [RESP_W-1:0] in_resp,
	output logic              in_ready,
	output logic              out_valid,
	output logic [LINE_W-1:0] out_data,
	input  logic              out_ready,
	input  logic              reg_valid,
	input  logic              reg_write,
	input  reg_addr_e         reg_addr,
	input  logic [31:0]       reg_wdata,
	output logic              reg_ready,
	output logic              reg_rvalid,
	output logic [31:0]       reg_rdata
);

	logic                     eng_pop_valid;
	logic                     eng_pop_ready;
	logic [LINE_W+RESP_W-1:0] eng_pop_data;
	logic                     eng_push_valid;
	logic                     eng_push_ready;
	logic [LINE_W-1:0]        eng_push_data;
	logic [LINE_W+RESP_W-1:0] out_pop_data;
	logic                     start;
	logic                     err_clear;
	logic                     busy;
	logic                     done_pulse;
	logic                     bus_error;
	logic                     line_pulse;

	assign out_data = out_pop_data[LINE_W-1:0]; // resp field is always OKAY here

	line_fifo #(
		.WIDTH (LINE_W + RESP_W),
		.DEPTH (FIFO_DEPTH),
		.PTR_W (PTR_W)
	) in_fifo (
		.clk_i      (clk_i),
		.rst_ni     (rst_ni),
		.push_valid (in_valid),
		.push_data  ({in_resp, in_data}),
		.push_ready (in_ready),
		.pop_valid  (eng_pop_valid),
		.pop_ready  (eng_pop_ready),
		.pop_data   (eng_pop_data)
	);

	decomp_regs decomp_regs_inst (
		.clk_i      (clk_i),
		.rst_ni     (rst_ni),
		.reg_valid  (reg_valid),
		.reg_write  (reg_write),
		.reg_addr   (reg_addr),
		.reg_wdata  (reg_wdata),
		.reg_ready  (reg_ready),
		.reg_rvalid (reg_rvalid),
		.reg_rdata  (reg_rdata),
		.busy       (busy),
		.done_pulse (done_pulse),
		.bus_error  (bus_error),
		.line_pulse (line_pulse),
		.start      (start),
		.err_clear  (err_clear)
	);

	page_decompressor page_decompressor_inst (
		.clk_i      (clk_i),
		.rst_ni     (rst_ni),
		.start      (start),
		.err_clear  (err_clear),
		.pop_valid  (eng_pop_valid),
		.pop_data   (eng_pop_data),
		.pop_ready  (eng_pop_ready),
		.push_valid (eng_push_valid),
		.push_data  (eng_push_data),
		.push_ready (eng_push_ready),
		.busy       (busy),
		.done_pulse (done_pulse),
		.bus_error  (bus_error),
		.line_pulse (line_pulse)
	);

	line_fifo #(
		.WIDTH (LINE_W + RESP_W),
		.DEPTH (FIFO_DEPTH),
		.PTR_W (PTR_W)
	) out_fifo (
		.clk_i      (clk_i),
		.rst_ni     (rst_ni),
		.push_valid (eng_push_valid),
		.push_data  ({RESP_OKAY, eng_push_data}),
		.push_ready (eng_push_ready),
		.pop_valid  (out_valid),
		.pop_ready  (out_ready),
		.pop_data   (out_pop_data)
	);

endmodule

/* tb/decomp_asserts.sv */
`timescale 1ns/1ps

module decomp_asserts
	import decomp_cfg_pkg::*;
(
	input logic              clk_i,
	input logic              rst_ni,
	input logic              in_ready,
	input logic              out_valid,
	input logic              out_ready,
	input logic [LINE_W-1:0] out_data,
	input logic              reg_valid,
	input logic              reg_ready,
	input logic              reg_write,
	input logic              reg_rvalid,
	input logic              bus_error
);

	int fail_cnt = 0;

	// a stalled output line stays put
	out_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
		out_valid && !out_ready |=> out_valid && $stable(out_data))
		else begin $error("output line changed or dropped under back-pressure"); fail_cnt++; end

	in_ready_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
		!$isunknown(in_ready))
		else begin $error("in_ready is unknown"); fail_cnt++; end

	rvalid_after_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
		reg_rvalid |-> $past(reg_valid && reg_ready && !reg_write))
		else begin $error("reg_rvalid without an accepted read"); fail_cnt++; end

	read_gives_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
		reg_valid && reg_ready && !reg_write |=> reg_rvalid)
		else begin $error("accepted read got no reg_rvalid"); fail_cnt++; end

	// engine pushes nothing while stuck in error
	quiet_in_error: assert property (@(posedge clk_i) disable iff (!rst_ni)
		bus_error && !out_valid |=> !out_valid)
		else begin $error("output line appeared during bus error"); fail_cnt++; end

endmodule

bind decomp_top decomp_asserts asserts_inst (.*);

/* tb/decomp_tb.sv */
`timescale 1ns/1ps

module decomp_tb
	import decomp_cfg_pkg::*;
	import decomp_ctrl_pkg::*;
();

	localparam logic [31:0] SEED = 32'h95a8;
	localparam int MAX_CYCLES = 4000; // six pages at ~8 cycles a line plus register traffic
	localparam logic [31:0] START_CMD = 32'h1 << CTRL_START_BIT;
	localparam logic [31:0] CLEAR_CMD = 32'h1 << CTRL_CLEAR_BIT;

	logic              clk_i = 1'b0;
	logic              rst_ni;
	logic              in_valid = 1'b0;
	logic [LINE_W-1:0] in_data = '0;
	logic [RESP_W-1:0] in_resp = '0;
	logic              in_ready;
	logic              out_valid;
	logic [LINE_W-1:0] out_data;
	logic              out_ready = 1'b0;
	logic              reg_valid;
	logic              reg_write;
	reg_addr_e         reg_addr;
	logic [31:0]       reg_wdata;
	logic              reg_ready;
	logic              reg_rvalid;
	logic [31:0]       reg_rdata;

	logic [LINE_W+RESP_W-1:0] send_q[$]; // {resp, data} in stream order
	logic [LINE_W-1:0]        exp_q[$];
	logic [LINE_W-1:0]        exp_line;
	logic [31:0]              data_rng = SEED;
	logic [31:0]              in_rng = SEED ^ 32'h5a5a;
	logic [31:0]              out_rng = SEED ^ 32'ha5a5;
	logic [31:0]              rd;
	int                       errors = 0;
	int                       cycles = 0;

	decomp_top decomp_top_inst (.*);

	always #10 clk_i = ~clk_i;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic logic [LINE_W-1:0] next_line();
		logic [31:0] hi;
		data_rng = xorshift(data_rng);
		hi = data_rng;
		data_rng = xorshift(data_rng);
		return {hi, data_rng};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
		assert (got == want) else begin
			errors++;
			$display("Error at %0t: %s expected %0h, got %0h", $time, name, want, got);
		end
	endtask

	// metadata, then data lines of unmasked chunks; bad_at >= 0 ends the page on a SLVERR line
	task automatic queue_page(input logic [3:0] mask, input int bad_at);
		logic [LINE_W-1:0] line;
		int n;
		line = next_line();
		send_q.push_back({RESP_OKAY, line[LINE_W-1:NUM_CHUNKS], mask});
		n = 0;
		for (int c = 0; c < NUM_CHUNKS; c++) begin
			for (int i = 0; i < CHUNK_LINES; i++) begin
				if (mask[c]) begin
					exp_q.push_back(LINE_W'(0));
				end else begin
					line = next_line();
					if (n == bad_at) begin
						send_q.push_back({RESP_SLVERR, line});
						return;
					end
					send_q.push_back({RESP_OKAY, line});
					exp_q.push_back(line);
					n++;
				end
			end
		end
	endtask

	task automatic reg_access(input logic wr, input reg_addr_e addr, input logic [31:0] wdata);
		reg_valid <= 1'b1;
		reg_write <= wr;
		reg_addr  <= addr;
		reg_wdata <= wdata;
		@(posedge clk_i);
		while (!reg_ready)
			@(posedge clk_i);
		reg_valid <= 1'b0;
		if (!wr) begin
			@(posedge clk_i);
			assert (reg_rvalid) else begin
				errors++;
				$display("Error at %0t: reg_rvalid missing one cycle after the read", $time);
			end
			rd = reg_rdata;
		end
	endtask

	task automatic finish_page();
		rd = '0;
		while (!rd[STAT_DONE_BIT])
			reg_access(1'b0, REG_STATUS, '0);
		while (exp_q.size() != 0)
			@(posedge clk_i);
		reg_access(1'b0, REG_LINES, '0);
		check_value("reg_rdata (LINES)", rd, 32'(PAGE_LINES));
	endtask

	task automatic run_page(input logic [3:0] mask);
		queue_page(mask, -1);
		reg_access(1'b1, REG_CTRL, START_CMD);
		finish_page();
	endtask

	// input stream driver with random gaps
	always @(posedge clk_i) begin
		if (in_valid && in_ready)
			void'(send_q.pop_front());
		if (!in_valid || in_ready) begin
			in_rng = xorshift(in_rng);
			in_valid <= (send_q.size() != 0) && (in_rng[1:0] != 2'd0);
			if (send_q.size() != 0) begin
				in_data <= send_q[0][LINE_W-1:0];
				in_resp <= send_q[0][LINE_W +: RESP_W];
			end
		end
	end

	// output monitor, out_ready toggles at random
	always @(posedge clk_i) begin
		if (out_valid && out_ready) begin
			assert (exp_q.size() != 0) else begin
				errors++;
				$display("Error at %0t: output line %h arrived with none expected", $time, out_data);
			end
			if (exp_q.size() != 0) begin
				exp_line = exp_q.pop_front();
				assert (out_data == exp_line) else begin
					errors++;
					$display("Error at %0t: out_data expected %h, got %h", $time, exp_line, out_data);
				end
			end
		end
		out_rng = xorshift(out_rng);
		out_ready <= (out_rng[1:0] != 2'd0);
	end

	initial begin
		while (cycles < MAX_CYCLES) begin
			@(posedge clk_i);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		rst_ni    <= 1'b0;
		reg_valid <= 1'b0;
		reg_write <= 1'b0;
		reg_addr  <= REG_CTRL;
		reg_wdata <= '0;
		repeat (3) @(posedge clk_i);
		rst_ni <= 1'b1;
		@(posedge clk_i);
		reg_access(1'b0, REG_STATUS, '0);
		check_value("reg_rdata (STATUS)", rd, 32'd0);
		reg_access(1'b0, REG_LINES, '0);
		check_value("reg_rdata (LINES)", rd, 32'd0);
		run_page(4'b0000);
		run_page(4'b1010);
		run_page(4'b1111); // only the metadata line goes in
		// SLVERR on the 21st data line, 20 lines come out first
		queue_page(4'b0000, 20);
		reg_access(1'b1, REG_CTRL, START_CMD);
		rd = '0;
		while (!rd[STAT_ERR_BIT])
			reg_access(1'b0, REG_STATUS, '0);
		while (exp_q.size() != 0)
			@(posedge clk_i);
		// next page piles up in the input FIFO while the engine sits in error
		queue_page(4'b0000, -1);
		while (in_ready)
			@(posedge clk_i);
		reg_access(1'b0, REG_STATUS, '0);
		check_value("reg_rdata (STATUS)", rd, 32'h1 << STAT_ERR_BIT);
		reg_access(1'b1, REG_CTRL, CLEAR_CMD);
		reg_access(1'b0, REG_STATUS, '0);
		check_value("reg_rdata (STATUS)", rd, 32'd0);
		reg_access(1'b1, REG_CTRL, START_CMD);
		finish_page();
		// second start lands mid page, once the first chunk is on its way out
		queue_page(4'b0000, -1);
		reg_access(1'b1, REG_CTRL, START_CMD);
		while (exp_q.size() > int'(PAGE_LINES - CHUNK_LINES))
			@(posedge clk_i);
		reg_access(1'b1, REG_CTRL, START_CMD);
		reg_access(1'b0, REG_STATUS, '0);
		check_value("reg_rdata (STATUS busy)", 32'(rd[STAT_BUSY_BIT]), 32'd1);
		finish_page();
		$display("checks finished: %0d mismatches, %0d assertion failures", errors,
			decomp_top_inst.asserts_inst.fail_cnt);
		if (errors == 0 && decomp_top_inst.asserts_inst.fail_cnt == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

/* build.f */
rtl/decomp_cfg_pkg.sv
rtl/decomp_ctrl_pkg.sv
rtl/line_fifo.sv
rtl/decomp_regs.sv
rtl/page_decompressor.sv
rtl/decomp_top.sv
tb/decomp_asserts.sv
tb/decomp_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the decompressor testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module decomp_tb -f build.f -o decomp_sim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

# keep running past assertion errors so the testbench prints its summary
./obj_dir/decomp_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
	exit 1
fi
exit 0
